//--- tb.f
+incdir+logic
logic/decode_pkg.sv
logic/rf_read_if.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/operand_forward.sv
logic/branch_unit.sv
logic/decode_stage.sv
verif/decode_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= decode_tb
FLIST     ?= tb.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- verif/decode_tb.sv
`include "decode_macros.svh"

module decode_tb;
    import decode_pkg::*;

    localparam int N_TRANS = 4000;
    localparam int PERIOD  = 100;

    // expected decode of one instruction
    typedef struct packed {
        logic [3:0]         alu;
        logic [`DATA_W-1:0] imm;
        logic [3:0]         mem;
        logic [3:0]         br;
        logic               src1_pc;
        logic               src2_imm;
        logic               src2_rd;
        logic               need1;
        logic               need2;
        logic               we;
        logic [`REG_AW-1:0] dest;
    } exp_t;

    logic clk = 1'b0;
    logic resetn;
    logic if_valid, ex_allowin;
    logic [`DATA_W-1:0] if_inst, if_pc;
    logic ex_fwd_we, ex_fwd_is_load, mem_fwd_we, mem_fwd_is_load, wb_we;
    logic [`REG_AW-1:0] ex_fwd_waddr, mem_fwd_waddr, wb_waddr;
    logic [`DATA_W-1:0] ex_fwd_wdata, mem_fwd_wdata, wb_wdata;
    logic id_allowin, br_taken, ex_valid, ex_rf_we;
    logic [`DATA_W-1:0] br_target, ex_src1, ex_src2, ex_pc, ex_store_data;
    logic [`REG_AW-1:0] ex_rf_waddr;
    alu_op_e ex_alu_op;
    mem_op_e ex_mem_op;

    integer seed = 25329;
    int n_errors = 0;
    int n_checks = 0;

    // reference state
    logic [`DATA_W-1:0] mrf [`REG_N];
    logic               m_valid;
    logic [`DATA_W-1:0] m_inst, m_pc;
    exp_t               cur, pend;

    decode_stage dut_i (.*);

    always #(PERIOD / 2) clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error: %s got %h expected %h at time %0t", name, got, exp, $time);
        end
    endtask

    // mostly r0..r7 so that producers often match
    function automatic logic [`REG_AW-1:0] rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return (r[4:3] == 2'b00) ? r[9:5] : {2'b00, r[2:0]};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic gen_inst(output logic [31:0] inst, output exp_t e);
        int kind;
        int sel;
        logic [4:0] rd, rj, rk, f5;
        logic [3:0] op4;
        logic [5:0] op6;
        logic [31:0] r;
        kind = {$random(seed)} % 11;
        sel  = {$random(seed)} % 64;
        r    = $random(seed);
        rd   = rand_reg();
        rj   = rand_reg();
        rk   = rand_reg();
        e    = '0;
        e.dest = rd;
        case (kind)
            0: begin
                case (sel % 11)
                    0: {f5, e.alu} = {5'h00, ALU_ADD};
                    1: {f5, e.alu} = {5'h02, ALU_SUB};
                    2: {f5, e.alu} = {5'h04, ALU_SLT};
                    3: {f5, e.alu} = {5'h05, ALU_SLTU};
                    4: {f5, e.alu} = {5'h08, ALU_NOR};
                    5: {f5, e.alu} = {5'h09, ALU_AND};
                    6: {f5, e.alu} = {5'h0a, ALU_OR};
                    7: {f5, e.alu} = {5'h0b, ALU_XOR};
                    8: {f5, e.alu} = {5'h0e, ALU_SLL};
                    9: {f5, e.alu} = {5'h0f, ALU_SRL};
                    default: {f5, e.alu} = {5'h10, ALU_SRA};
                endcase
                inst = {6'h00, 4'h0, 2'h1, f5, rk, rj, rd};
                {e.need1, e.need2, e.we} = 3'b111;
            end
            1: begin
                case (sel % 3)
                    0: {f5, e.alu} = {5'h01, ALU_SLL};
                    1: {f5, e.alu} = {5'h09, ALU_SRL};
                    default: {f5, e.alu} = {5'h11, ALU_SRA};
                endcase
                inst = {6'h00, 4'h1, 2'h0, f5, r[4:0], rj, rd};
                e.imm = sext12(inst[21:10]);
                {e.src2_imm, e.need1, e.we} = 3'b111;
            end
            2: begin
                case (sel % 6)
                    0: {op4, e.alu} = {4'h8, ALU_SLT};
                    1: {op4, e.alu} = {4'h9, ALU_SLTU};
                    2: {op4, e.alu} = {4'ha, ALU_ADD};
                    3: {op4, e.alu} = {4'hd, ALU_AND};
                    4: {op4, e.alu} = {4'he, ALU_OR};
                    default: {op4, e.alu} = {4'hf, ALU_XOR};
                endcase
                inst  = {6'h00, op4, r[11:0], rj, rd};
                e.imm = (op4 >= 4'hd) ? {20'h0, r[11:0]} : sext12(r[11:0]);
                {e.src2_imm, e.need1, e.we} = 3'b111;
            end
            3: begin
                op6   = sel[0] ? 6'h07 : 6'h05;
                e.alu = sel[0] ? ALU_ADD : ALU_LUI;
                e.src1_pc = sel[0];
                inst  = {op6, 1'b0, r[19:0], rd};
                e.imm = {r[19:0], 12'h0};
                {e.src2_imm, e.we} = 2'b11;
            end
            4, 5: begin
                if (kind == 4) begin
                    case (sel % 5)
                        0: {op4, e.mem} = {4'h0, MEM_LD_B};
                        1: {op4, e.mem} = {4'h1, MEM_LD_H};
                        2: {op4, e.mem} = {4'h2, MEM_LD_W};
                        3: {op4, e.mem} = {4'h8, MEM_LD_BU};
                        default: {op4, e.mem} = {4'h9, MEM_LD_HU};
                    endcase
                    e.we = 1'b1;
                end else begin
                    case (sel % 3)
                        0: {op4, e.mem} = {4'h4, MEM_ST_B};
                        1: {op4, e.mem} = {4'h5, MEM_ST_H};
                        default: {op4, e.mem} = {4'h6, MEM_ST_W};
                    endcase
                    {e.need2, e.src2_rd} = 2'b11;
                end
                inst  = {6'h0a, op4, r[11:0], rj, rd};
                e.alu = ALU_ADD;
                e.imm = sext12(r[11:0]);
                {e.src2_imm, e.need1} = 2'b11;
            end
            6: begin
                e.br = 4'(1 + sel % 6);
                inst = {6'h15 + 6'(e.br), r[15:0], rj, rd};
                {e.need1, e.need2, e.src2_rd} = 3'b111;
            end
            7, 8, 9: begin
                op6  = (kind == 7) ? 6'h14 : (kind == 8) ? 6'h15 : 6'h13;
                inst = (kind == 9) ? {op6, r[15:0], rj, rd} : {op6, r[25:0]};
                e.br = 4'(kind);
                e.dest = (kind == 8) ? 5'd1 : inst[4:0];
                if (kind != 7) begin
                    e.alu = ALU_ADD;
                    e.imm = 32'd4;
                    {e.src1_pc, e.src2_imm, e.we} = 3'b111;
                    e.need1 = (kind == 9);
                end
            end
            default: begin
                // unknown opcode decodes as an all-zero no-op
                inst   = {6'h3f, r[25:0]};
                e.dest = '0;
            end
        endcase
    endtask

    function automatic logic [31:0] fwd_value(input logic [4:0] a);
        if (a == 5'd0) return 32'h0;
        if (ex_fwd_we && ex_fwd_waddr == a) return ex_fwd_wdata;
        if (mem_fwd_we && mem_fwd_waddr == a) return mem_fwd_wdata;
        if (wb_we && wb_waddr == a) return wb_wdata;
        return mrf[a];
    endfunction

    function automatic logic load_match(input logic [4:0] a);
        return (a != 5'd0) && ((ex_fwd_we && ex_fwd_is_load && ex_fwd_waddr == a)
               || (mem_fwd_we && mem_fwd_is_load && mem_fwd_waddr == a));
    endfunction

    function automatic logic br_cond(input logic [3:0] br, input logic [31:0] a,
                                     input logic [31:0] b);
        case (br)
            1: return a == b;
            2: return a != b;
            3: return $signed(a) < $signed(b);
            4: return $signed(a) >= $signed(b);
            5: return a < b;
            6: return a >= b;
            7, 8, 9: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // check this cycle's outputs and advance the model past the next edge
    task automatic check_cycle();
        logic [4:0] s2a;
        logic [31:0] v1, v2, o16, o26, tgt;
        logic haz, exp_ev, exp_allow, taken;
        s2a = cur.src2_rd ? m_inst[4:0] : m_inst[14:10];
        v1  = fwd_value(m_inst[9:5]);
        v2  = fwd_value(s2a);
        haz = (cur.need1 && load_match(m_inst[9:5])) || (cur.need2 && load_match(s2a));
        exp_ev    = m_valid && !haz;
        exp_allow = !m_valid || (!haz && ex_allowin);
        taken     = exp_ev && ex_allowin && br_cond(cur.br, v1, v2);
        compare_value("ex_valid", ex_valid, exp_ev);
        compare_value("id_allowin", id_allowin, exp_allow);
        compare_value("br_taken", br_taken, taken);
        if (exp_ev) begin
            compare_value("ex_alu_op", ex_alu_op, cur.alu);
            compare_value("ex_src1", ex_src1, cur.src1_pc ? m_pc : v1);
            compare_value("ex_src2", ex_src2, cur.src2_imm ? cur.imm : v2);
            compare_value("ex_rf_we", ex_rf_we, cur.we);
            compare_value("ex_rf_waddr", ex_rf_waddr, cur.dest);
            compare_value("ex_pc", ex_pc, m_pc);
            compare_value("ex_mem_op", ex_mem_op, cur.mem);
            compare_value("ex_store_data", ex_store_data, v2);
        end
        if (taken) begin
            o16 = {{14{m_inst[25]}}, m_inst[25:10], 2'b00};
            o26 = {{4{m_inst[9]}}, m_inst[9:0], m_inst[25:10], 2'b00};
            tgt = (cur.br == 4'd9) ? v1 + o16 : (cur.br >= 4'd7) ? m_pc + o26 : m_pc + o16;
            compare_value("br_target", br_target, tgt);
        end
        if (if_valid && exp_allow) begin
            cur    = pend;
            m_inst = if_inst;
            m_pc   = if_pc;
        end
        if (taken) begin
            m_valid = 1'b0;
        end else if (exp_allow) begin
            m_valid = if_valid;
        end
        if (wb_we && wb_waddr != 5'd0) begin
            mrf[wb_waddr] = wb_wdata;
        end
    endtask

    task automatic drive_random();
        if_valid = ($random(seed) & 3) != 0;
        gen_inst(if_inst, pend);
        if_pc      = $random(seed) & 32'hffff_fffc;
        ex_allowin = ($random(seed) & 3) != 0;
        ex_fwd_we       = $random(seed);
        ex_fwd_is_load  = ($random(seed) & 7) == 0;
        ex_fwd_waddr    = rand_reg();
        ex_fwd_wdata    = $random(seed);
        mem_fwd_we      = $random(seed);
        mem_fwd_is_load = ($random(seed) & 7) == 0;
        mem_fwd_waddr   = rand_reg();
        mem_fwd_wdata   = $random(seed);
        wb_we    = $random(seed);
        wb_waddr = rand_reg();
        wb_wdata = $random(seed);
    endtask

    initial begin
        #(N_TRANS * 20 * PERIOD);
        $display("timeout: the run did not finish within the expected time");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        resetn = 1'b0;
        {if_valid, ex_allowin, ex_fwd_we, ex_fwd_is_load} = '0;
        {mem_fwd_we, mem_fwd_is_load, wb_we} = '0;
        {if_inst, if_pc, ex_fwd_wdata, mem_fwd_wdata, wb_wdata} = '0;
        {ex_fwd_waddr, mem_fwd_waddr, wb_waddr} = '0;
        m_valid = 1'b0;
        cur = '0;
        pend = '0;
        m_inst = '0;
        m_pc = '0;
        repeat (16) begin
            @(negedge clk);
            compare_value("ex_valid", ex_valid, 1'b0);
            compare_value("br_taken", br_taken, 1'b0);
            compare_value("id_allowin", id_allowin, 1'b1);
        end
        resetn = 1'b1;
        // fill every register through WB including r0
        for (int i = 0; i < `REG_N; i++) begin
            wb_we    = 1'b1;
            wb_waddr = 5'(i);
            wb_wdata = $random(seed);
            #10;
            check_cycle();
            @(negedge clk);
        end
        for (int n = 0; n < N_TRANS; n++) begin
            drive_random();
            #10;
            check_cycle();
            @(negedge clk);
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- logic/decode_stage.sv
`include "decode_macros.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 if_valid,
    input  logic [`DATA_W-1:0]   if_inst,
    input  logic [`DATA_W-1:0]   if_pc,
    output logic                 id_allowin,
    output logic                 br_taken,
    output logic [`DATA_W-1:0]   br_target,
    input  logic                 ex_allowin,
    output logic                 ex_valid,
    output decode_pkg::alu_op_e  ex_alu_op,
    output logic [`DATA_W-1:0]   ex_src1,
    output logic [`DATA_W-1:0]   ex_src2,
    output logic                 ex_rf_we,
    output logic [`REG_AW-1:0]   ex_rf_waddr,
    output logic [`DATA_W-1:0]   ex_pc,
    output decode_pkg::mem_op_e  ex_mem_op,
    output logic [`DATA_W-1:0]   ex_store_data,
    input  logic                 ex_fwd_we,
    input  logic [`REG_AW-1:0]   ex_fwd_waddr,
    input  logic [`DATA_W-1:0]   ex_fwd_wdata,
    input  logic                 ex_fwd_is_load,
    input  logic                 mem_fwd_we,
    input  logic [`REG_AW-1:0]   mem_fwd_waddr,
    input  logic [`DATA_W-1:0]   mem_fwd_wdata,
    input  logic                 mem_fwd_is_load,
    input  logic                 wb_we,
    input  logic [`REG_AW-1:0]   wb_waddr,
    input  logic [`DATA_W-1:0]   wb_wdata
);
    import decode_pkg::*;

    logic               id_valid;
    logic [`DATA_W-1:0] id_inst;
    logic [`DATA_W-1:0] id_pc;
    dec_ctrl_t          ctrl;
    logic               hazard;
    logic               ready_go;
    logic               ex_fire;
    logic [`DATA_W-1:0] rj_value;
    logic [`DATA_W-1:0] rkd_value;
    logic [`DATA_W-1:0] imm;
    logic [`INST_I12_W-1:0] i12;

    rf_read_if rf_bus ();

    assign ready_go   = !hazard;
    assign id_allowin = !id_valid || (ready_go && ex_allowin);
    assign ex_valid   = id_valid && ready_go;
    assign ex_fire    = ex_valid && ex_allowin;

    // a taken branch squashes whatever IF offers this cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allowin) begin
            id_inst <= if_inst;
            id_pc   <= if_pc;
        end
    end

    inst_decoder dec_i (
        .inst (id_inst),
        .ctrl (ctrl)
    );

    reg_file rf_i (
        .clk     (clk),
        .rd_port (rf_bus),
        .we      (wb_we),
        .waddr   (wb_waddr),
        .wdata   (wb_wdata)
    );

    operand_forward fwd_i (
        .rd_port         (rf_bus),
        .ctrl            (ctrl),
        .rj              (id_inst[`INST_RJ_LSB +: `REG_AW]),
        .rk              (id_inst[`INST_RK_LSB +: `REG_AW]),
        .rd              (id_inst[`INST_RD_LSB +: `REG_AW]),
        .ex_fwd_we       (ex_fwd_we),
        .ex_fwd_waddr    (ex_fwd_waddr),
        .ex_fwd_wdata    (ex_fwd_wdata),
        .ex_fwd_is_load  (ex_fwd_is_load),
        .mem_fwd_we      (mem_fwd_we),
        .mem_fwd_waddr   (mem_fwd_waddr),
        .mem_fwd_wdata   (mem_fwd_wdata),
        .mem_fwd_is_load (mem_fwd_is_load),
        .wb_we           (wb_we),
        .wb_waddr        (wb_waddr),
        .wb_wdata        (wb_wdata),
        .rj_value        (rj_value),
        .rkd_value       (rkd_value),
        .hazard          (hazard)
    );

    branch_unit br_i (
        .br_op     (ctrl.br_op),
        .pc        (id_pc),
        .inst      (id_inst),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .take_en   (ex_fire),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    assign i12 = id_inst[`INST_I12_LSB +: `INST_I12_W];

    // ui5 sits in the low bits of the same field
    always_comb begin
        case (ctrl.imm_kind)
            IMM_UI5, IMM_SI12: imm = {{(`DATA_W-`INST_I12_W){i12[`INST_I12_W-1]}}, i12};
            IMM_UI12:          imm = {{(`DATA_W-`INST_I12_W){1'b0}}, i12};
            IMM_SI20:          imm = {id_inst[`INST_I20_LSB +: `INST_I20_W],
                                      {(`DATA_W-`INST_I20_W){1'b0}}};
            IMM_FOUR:          imm = `DATA_W'd4;
            default:           imm = '0;
        endcase
    end

    assign ex_alu_op     = ctrl.alu_op;
    assign ex_src1       = ctrl.src1_is_pc ? id_pc : rj_value;
    assign ex_src2       = ctrl.src2_is_imm ? imm : rkd_value;
    assign ex_rf_we      = ctrl.rf_we;
    assign ex_rf_waddr   = ctrl.dest;
    assign ex_pc         = id_pc;
    assign ex_mem_op     = ctrl.mem_op;
    assign ex_store_data = rkd_value;

endmodule

//--- logic/branch_unit.sv
`include "decode_macros.svh"

module branch_unit (
    input  decode_pkg::br_op_e   br_op,
    input  logic [`DATA_W-1:0]   pc,
    input  logic [`DATA_W-1:0]   inst,
    input  logic [`DATA_W-1:0]   rj_value,
    input  logic [`DATA_W-1:0]   rkd_value,
    input  logic                 take_en,
    output logic                 br_taken,
    output logic [`DATA_W-1:0]   br_target
);
    import decode_pkg::*;

    logic [`DATA_W:0]   diff;
    logic               eq;
    logic               lt_s;
    logic               lt_u;
    logic               cond;
    logic [`DATA_W-1:0] offs16;
    logic [`DATA_W-1:0] offs26;

    // one subtractor for both orderings
    assign diff = {1'b0, rj_value} - {1'b0, rkd_value};
    assign eq   = (rj_value == rkd_value);
    assign lt_u = diff[`DATA_W];
    assign lt_s = (rj_value[`DATA_W-1] != rkd_value[`DATA_W-1]) ?
                  rj_value[`DATA_W-1] : diff[`DATA_W-1];

    assign offs16 = {{(`DATA_W-`INST_I16_W-2){inst[`INST_I16_LSB+`INST_I16_W-1]}},
                     inst[`INST_I16_LSB +: `INST_I16_W], 2'b00};
    assign offs26 = {{(`DATA_W-`INST_I16_W-`INST_OFFS26_HI_W-2)
                        {inst[`INST_OFFS26_HI_LSB+`INST_OFFS26_HI_W-1]}},
                     inst[`INST_OFFS26_HI_LSB +: `INST_OFFS26_HI_W],
                     inst[`INST_I16_LSB +: `INST_I16_W], 2'b00};

    always_comb begin
        case (br_op)
            BR_BEQ:                cond = eq;
            BR_BNE:                cond = !eq;
            BR_BLT:                cond = lt_s;
            BR_BGE:                cond = !lt_s;
            BR_BLTU:               cond = lt_u;
            BR_BGEU:               cond = !lt_u;
            BR_B, BR_BL, BR_JIRL:  cond = 1'b1;
            default:               cond = 1'b0;
        endcase
    end

    always_comb begin
        case (br_op)
            BR_JIRL:     br_target = rj_value + offs16;
            BR_B, BR_BL: br_target = pc + offs26;
            default:     br_target = pc + offs16;
        endcase
    end

    // only when EX takes the instruction
    assign br_taken = take_en && cond;

endmodule

//--- logic/operand_forward.sv
`include "decode_macros.svh"

module operand_forward (
    rf_read_if.fwd               rd_port,
    input  decode_pkg::dec_ctrl_t ctrl,
    input  logic [`REG_AW-1:0]   rj,
    input  logic [`REG_AW-1:0]   rk,
    input  logic [`REG_AW-1:0]   rd,
    input  logic                 ex_fwd_we,
    input  logic [`REG_AW-1:0]   ex_fwd_waddr,
    input  logic [`DATA_W-1:0]   ex_fwd_wdata,
    input  logic                 ex_fwd_is_load,
    input  logic                 mem_fwd_we,
    input  logic [`REG_AW-1:0]   mem_fwd_waddr,
    input  logic [`DATA_W-1:0]   mem_fwd_wdata,
    input  logic                 mem_fwd_is_load,
    input  logic                 wb_we,
    input  logic [`REG_AW-1:0]   wb_waddr,
    input  logic [`DATA_W-1:0]   wb_wdata,
    output logic [`DATA_W-1:0]   rj_value,
    output logic [`DATA_W-1:0]   rkd_value,
    output logic                 hazard
);

    logic [`REG_AW-1:0] src2_addr;
    logic               r1_ex;
    logic               r1_mem;
    logic               r1_wb;
    logic               r2_ex;
    logic               r2_mem;
    logic               r2_wb;

    // r0 never matches a producer
    function automatic logic match(
        input logic [`REG_AW-1:0] src,
        input logic               we,
        input logic [`REG_AW-1:0] waddr
    );
        return we && (src != '0) && (src == waddr);
    endfunction

    // stores and conditional branches read rd instead of rk
    assign src2_addr      = ctrl.src2_is_rd ? rd : rk;
    assign rd_port.raddr1 = rj;
    assign rd_port.raddr2 = src2_addr;

    assign r1_ex  = match(rj, ex_fwd_we, ex_fwd_waddr);
    assign r1_mem = match(rj, mem_fwd_we, mem_fwd_waddr);
    assign r1_wb  = match(rj, wb_we, wb_waddr);
    assign r2_ex  = match(src2_addr, ex_fwd_we, ex_fwd_waddr);
    assign r2_mem = match(src2_addr, mem_fwd_we, mem_fwd_waddr);
    assign r2_wb  = match(src2_addr, wb_we, wb_waddr);

    // youngest producer wins
    assign rj_value  = r1_ex  ? ex_fwd_wdata  :
                       r1_mem ? mem_fwd_wdata :
                       r1_wb  ? wb_wdata      : rd_port.rdata1;
    assign rkd_value = r2_ex  ? ex_fwd_wdata  :
                       r2_mem ? mem_fwd_wdata :
                       r2_wb  ? wb_wdata      : rd_port.rdata2;

    // load data not yet available in EX or MEM
    assign hazard = (ctrl.need_r1 && ((r1_ex && ex_fwd_is_load) || (r1_mem && mem_fwd_is_load)))
                 || (ctrl.need_r2 && ((r2_ex && ex_fwd_is_load) || (r2_mem && mem_fwd_is_load)));

endmodule

//--- logic/reg_file.sv
`include "decode_macros.svh"

module reg_file (
    input  logic               clk,
    rf_read_if.rf              rd_port,
    input  logic               we,
    input  logic [`REG_AW-1:0] waddr,
    input  logic [`DATA_W-1:0] wdata
);

    logic [`DATA_W-1:0] regs [`REG_N];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads with r0 forced to zero
    assign rd_port.rdata1 = (rd_port.raddr1 == '0) ? '0 : regs[rd_port.raddr1];
    assign rd_port.rdata2 = (rd_port.raddr2 == '0) ? '0 : regs[rd_port.raddr2];

endmodule

//--- logic/inst_decoder.sv
`include "decode_macros.svh"

module inst_decoder (
    input  logic [`DATA_W-1:0]    inst,
    output decode_pkg::dec_ctrl_t ctrl
);
    import decode_pkg::*;

    logic [5:0]         op_31_26;
    logic [3:0]         op_25_22;
    logic [1:0]         op_21_20;
    logic [4:0]         op_19_15;
    logic [`REG_AW-1:0] rd;
    logic               known;

    assign op_31_26 = inst[`INST_OP6_LSB +: 6];
    assign op_25_22 = inst[`INST_OP4_LSB +: 4];
    assign op_21_20 = inst[`INST_OP2_LSB +: 2];
    assign op_19_15 = inst[`INST_OP5_LSB +: 5];
    assign rd       = inst[`INST_RD_LSB +: `REG_AW];

    always_comb begin
        ctrl      = '0;
        ctrl.dest = rd;
        known     = 1'b1;
        if (op_31_26 == 6'h00 && op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
            // three-register alu ops
            ctrl.need_r1 = 1'b1;
            ctrl.need_r2 = 1'b1;
            ctrl.rf_we   = 1'b1;
            case (op_19_15)
                5'h00:   ctrl.alu_op = ALU_ADD;
                5'h02:   ctrl.alu_op = ALU_SUB;
                5'h04:   ctrl.alu_op = ALU_SLT;
                5'h05:   ctrl.alu_op = ALU_SLTU;
                5'h08:   ctrl.alu_op = ALU_NOR;
                5'h09:   ctrl.alu_op = ALU_AND;
                5'h0a:   ctrl.alu_op = ALU_OR;
                5'h0b:   ctrl.alu_op = ALU_XOR;
                5'h0e:   ctrl.alu_op = ALU_SLL;
                5'h0f:   ctrl.alu_op = ALU_SRL;
                5'h10:   ctrl.alu_op = ALU_SRA;
                default: known = 1'b0;
            endcase
        end else if (op_31_26 == 6'h00 && op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
            // shift by ui5
            ctrl.imm_kind    = IMM_UI5;
            ctrl.src2_is_imm = 1'b1;
            ctrl.need_r1     = 1'b1;
            ctrl.rf_we       = 1'b1;
            case (op_19_15)
                5'h01:   ctrl.alu_op = ALU_SLL;
                5'h09:   ctrl.alu_op = ALU_SRL;
                5'h11:   ctrl.alu_op = ALU_SRA;
                default: known = 1'b0;
            endcase
        end else if (op_31_26 == 6'h00) begin
            ctrl.src2_is_imm = 1'b1;
            ctrl.need_r1     = 1'b1;
            ctrl.rf_we       = 1'b1;
            ctrl.imm_kind    = IMM_SI12;
            case (op_25_22)
                4'h8:    ctrl.alu_op = ALU_SLT;
                4'h9:    ctrl.alu_op = ALU_SLTU;
                4'ha:    ctrl.alu_op = ALU_ADD;
                4'hd:    {ctrl.alu_op, ctrl.imm_kind} = {ALU_AND, IMM_UI12};
                4'he:    {ctrl.alu_op, ctrl.imm_kind} = {ALU_OR, IMM_UI12};
                4'hf:    {ctrl.alu_op, ctrl.imm_kind} = {ALU_XOR, IMM_UI12};
                default: known = 1'b0;
            endcase
        end else if ((op_31_26 == 6'h05 || op_31_26 == 6'h07) && !inst[25]) begin
            // lu12i.w and pcaddu12i
            ctrl.imm_kind    = IMM_SI20;
            ctrl.src2_is_imm = 1'b1;
            ctrl.rf_we       = 1'b1;
            ctrl.src1_is_pc  = (op_31_26 == 6'h07);
            ctrl.alu_op      = (op_31_26 == 6'h07) ? ALU_ADD : ALU_LUI;
        end else if (op_31_26 == 6'h0a) begin
            // address is rj + si12
            ctrl.alu_op      = ALU_ADD;
            ctrl.imm_kind    = IMM_SI12;
            ctrl.src2_is_imm = 1'b1;
            ctrl.need_r1     = 1'b1;
            ctrl.rf_we       = 1'b1;
            case (op_25_22)
                4'h0:    ctrl.mem_op = MEM_LD_B;
                4'h1:    ctrl.mem_op = MEM_LD_H;
                4'h2:    ctrl.mem_op = MEM_LD_W;
                4'h8:    ctrl.mem_op = MEM_LD_BU;
                4'h9:    ctrl.mem_op = MEM_LD_HU;
                4'h4:    ctrl.mem_op = MEM_ST_B;
                4'h5:    ctrl.mem_op = MEM_ST_H;
                4'h6:    ctrl.mem_op = MEM_ST_W;
                default: known = 1'b0;
            endcase
            if (op_25_22[3:2] == 2'b01) begin
                // stores read rd as data
                ctrl.rf_we      = 1'b0;
                ctrl.need_r2    = 1'b1;
                ctrl.src2_is_rd = 1'b1;
            end
        end else if (op_31_26 >= 6'h16 && op_31_26 <= 6'h1b) begin
            ctrl.need_r1    = 1'b1;
            ctrl.need_r2    = 1'b1;
            ctrl.src2_is_rd = 1'b1;
            ctrl.br_op      = br_op_e'(op_31_26 - 6'h15);
        end else if (op_31_26 == 6'h14) begin
            ctrl.br_op = BR_B;
        end else if (op_31_26 == 6'h15 || op_31_26 == 6'h13) begin
            // bl and jirl write the return address pc + 4
            ctrl.alu_op      = ALU_ADD;
            ctrl.imm_kind    = IMM_FOUR;
            ctrl.src1_is_pc  = 1'b1;
            ctrl.src2_is_imm = 1'b1;
            ctrl.rf_we       = 1'b1;
            ctrl.br_op       = (op_31_26 == 6'h15) ? BR_BL : BR_JIRL;
            ctrl.need_r1     = (op_31_26 == 6'h13);
            if (op_31_26 == 6'h15) begin
                ctrl.dest = `REG_AW'd1;
            end
        end else begin
            known = 1'b0;
        end
        // unknown codes act as a no-op
        if (!known) begin
            ctrl = '0;
        end
    end

endmodule

//--- logic/rf_read_if.sv
`include "decode_macros.svh"

interface rf_read_if;

    logic [`REG_AW-1:0] raddr1;
    logic [`REG_AW-1:0] raddr2;
    logic [`DATA_W-1:0] rdata1;
    logic [`DATA_W-1:0] rdata2;

    // forwarding side drives the addresses
    modport fwd (
        output raddr1,
        output raddr2,
        input  rdata1,
        input  rdata2
    );

    modport rf (
        input  raddr1,
        input  raddr2,
        output rdata1,
        output rdata2
    );

endinterface

//--- logic/decode_pkg.sv
`include "decode_macros.svh"

package decode_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_UI5,
        IMM_UI12,
        IMM_SI12,
        IMM_SI20,
        IMM_FOUR
    } imm_kind_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LD_B,
        MEM_LD_H,
        MEM_LD_W,
        MEM_LD_BU,
        MEM_LD_HU,
        MEM_ST_B,
        MEM_ST_H,
        MEM_ST_W
    } mem_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_B,
        BR_BL,
        BR_JIRL
    } br_op_e;

    // decoded control for the instruction held in the stage
    typedef struct packed {
        alu_op_e            alu_op;
        imm_kind_e          imm_kind;
        mem_op_e            mem_op;
        br_op_e             br_op;
        logic               src1_is_pc;
        logic               src2_is_imm;
        logic               src2_is_rd;
        logic               need_r1;
        logic               need_r2;
        logic               rf_we;
        logic [`REG_AW-1:0] dest;
    } dec_ctrl_t;

endpackage

//--- logic/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// datapath and register file geometry
`define DATA_W 32
`define REG_AW 5
`define REG_N 32

// register fields
`define INST_RD_LSB 0
`define INST_RJ_LSB 5
`define INST_RK_LSB 10

// immediate fields
`define INST_I12_LSB 10
`define INST_I12_W 12
`define INST_I16_LSB 10
`define INST_I16_W 16
`define INST_I20_LSB 5
`define INST_I20_W 20

// high part of the 26-bit offset sits in bits 9..0
`define INST_OFFS26_HI_LSB 0
`define INST_OFFS26_HI_W 10

// opcode fields
`define INST_OP6_LSB 26
`define INST_OP4_LSB 22
`define INST_OP2_LSB 20
`define INST_OP5_LSB 15

`endif
